/* hdl/core_irq_pkg.sv */
package core_irq_pkg;

  ////////////////////
  // Widths

  // Data and irq word width
  localparam int unsigned XLEN       = 32;
  // CSR address width
  localparam int unsigned CSR_ADDR_W = 12;
  // Interrupt id width
  localparam int unsigned IRQ_ID_W   = 5;

  ////////////////////
  // CSR addresses

  localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

  // Implemented interrupt bits: MSI, MTI, MEI and fast irqs 31..16
  localparam logic [XLEN-1:0] MIE_MASK = 32'hFFFF_0888;

  // mstatus bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  // Standard interrupt ids
  localparam logic [IRQ_ID_W-1:0] IRQ_MSI = 5'd3;
  localparam logic [IRQ_ID_W-1:0] IRQ_MTI = 5'd7;
  localparam logic [IRQ_ID_W-1:0] IRQ_MEI = 5'd11;

  ////////////////////
  // Priority

  // Fast irqs first, highest index wins, then MEI > MSI > MTI
  function automatic logic [IRQ_ID_W-1:0] irq_priority_id(input logic [XLEN-1:0] pending);
    logic [IRQ_ID_W-1:0] id;
    logic                found;
    id    = '0;
    found = 1'b0;
    // Scan down from bit 31 so the first hit is the highest
    for (int i = XLEN - 1; i >= 16; i--) begin
      if (pending[i] && !found) begin
        id    = IRQ_ID_W'(i);
        found = 1'b1;
      end
    end
    // Standard interrupts only when no fast irq pending
    if (!found) begin
      if (pending[IRQ_MEI]) begin
        id = IRQ_MEI;
      end else if (pending[IRQ_MSI]) begin
        id = IRQ_MSI;
      end else if (pending[IRQ_MTI]) begin
        id = IRQ_MTI;
      end
    end
    return id;
  endfunction

endpackage

/* hdl/irq_csr_if.sv */
interface irq_csr_if;

  // Enable word and global enable, from CSRs
  logic [core_irq_pkg::XLEN-1:0]     mie;
  logic                              m_irq_enable;
  // Pending word and selected id, from interrupt controller
  logic [core_irq_pkg::XLEN-1:0]     mip;
  logic [core_irq_pkg::IRQ_ID_W-1:0] irq_id;

  // CSR side
  modport csr (
    output mie,
    output m_irq_enable,
    input  mip,
    input  irq_id
  );

  // Interrupt controller side
  modport intc (
    input  mie,
    input  m_irq_enable,
    output mip,
    output irq_id
  );

endinterface

/* hdl/irq_csr_regs.sv */
module irq_csr_regs (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // CSR access
  input  logic                                csr_we_i,
  input  logic [core_irq_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [core_irq_pkg::XLEN-1:0]       csr_wdata_i,
  output logic [core_irq_pkg::XLEN-1:0]       csr_rdata_o,
  // Trap events
  input  logic                                irq_ack_i,
  input  logic                                mret_i,
  // To/from interrupt controller
  irq_csr_if.csr                              irq_if
);

  // mstatus, only MIE and MPIE implemented
  logic                              mstatus_mie_q;
  logic                              mstatus_mpie_q;
  logic [core_irq_pkg::XLEN-1:0]     mie_q;
  // mcause split into interrupt flag and id
  logic                              mcause_irq_q;
  logic [core_irq_pkg::IRQ_ID_W-1:0] mcause_id_q;

  // Write decode
  logic mstatus_we;
  logic mie_we;

  assign mstatus_we = csr_we_i && (csr_addr_i == core_irq_pkg::CSR_MSTATUS);
  assign mie_we     = csr_we_i && (csr_addr_i == core_irq_pkg::CSR_MIE);

  ////////////////////
  // mstatus

  // Trap entry and mret take precedence over software write
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (irq_ack_i) begin
      // Stack MIE, disable interrupts
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_i) begin
      // Restore MIE from stack
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (mstatus_we) begin
      mstatus_mie_q  <= csr_wdata_i[core_irq_pkg::MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wdata_i[core_irq_pkg::MSTATUS_MPIE_BIT];
    end
  end

  ////////////////////
  // mie and mcause

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mie_q <= '0;
    end else if (mie_we) begin
      // Unimplemented bits stay zero
      mie_q <= csr_wdata_i & core_irq_pkg::MIE_MASK;
    end
  end

  // Only written by hardware on trap entry
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mcause_irq_q <= 1'b0;
      mcause_id_q  <= '0;
    end else if (irq_ack_i) begin
      mcause_irq_q <= 1'b1;
      mcause_id_q  <= irq_if.irq_id;
    end
  end

  ////////////////////
  // Read mux

  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      core_irq_pkg::CSR_MSTATUS: begin
        csr_rdata_o[core_irq_pkg::MSTATUS_MIE_BIT]  = mstatus_mie_q;
        csr_rdata_o[core_irq_pkg::MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      core_irq_pkg::CSR_MIE:    csr_rdata_o = mie_q;
      core_irq_pkg::CSR_MIP:    csr_rdata_o = irq_if.mip;
      core_irq_pkg::CSR_MCAUSE: begin
        csr_rdata_o[core_irq_pkg::XLEN-1]       = mcause_irq_q;
        csr_rdata_o[core_irq_pkg::IRQ_ID_W-1:0] = mcause_id_q;
      end
      default: ;
    endcase
  end

  // To interrupt controller
  assign irq_if.mie          = mie_q;
  assign irq_if.m_irq_enable = mstatus_mie_q;

  // Trap entry and return never in the same cycle
  a_ack_mret_excl : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(irq_ack_i && mret_i)
  ) else $error("irq_ack_i and mret_i high together");

endmodule

/* hdl/int_controller.sv */
module int_controller #(
  parameter int unsigned IRQ_SYNC_STAGES = 2
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  // Asynchronous external interrupt lines
  input  logic [core_irq_pkg::XLEN-1:0] irq_i,
  // To core
  output logic                          irq_req_o,
  output logic                          irq_wakeup_o,
  // To/from CSRs
  irq_csr_if.intc                       irq_if
);

  // Synchronizer chain with stage 0 sampling irq_i
  logic [core_irq_pkg::XLEN-1:0] irq_sync_q [IRQ_SYNC_STAGES];
  logic [core_irq_pkg::XLEN-1:0] mip_q;
  // Pending and enabled
  logic [core_irq_pkg::XLEN-1:0] irq_pending;

  // At least one sync flop needed
  if (IRQ_SYNC_STAGES < 1) begin : g_bad_stages
    $error("IRQ_SYNC_STAGES must be at least 1");
  end

  ////////////////////
  // Synchronizer

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < IRQ_SYNC_STAGES; i++) begin
        irq_sync_q[i] <= '0;
      end
    end else begin
      irq_sync_q[0] <= irq_i;
      for (int i = 1; i < IRQ_SYNC_STAGES; i++) begin
        irq_sync_q[i] <= irq_sync_q[i-1];
      end
    end
  end

  // mip register one edge after the last sync stage
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mip_q <= '0;
    end else begin
      // Drop unimplemented lines
      mip_q <= irq_sync_q[IRQ_SYNC_STAGES-1] & core_irq_pkg::MIE_MASK;
    end
  end

  ////////////////////
  // Request and id

  assign irq_pending = mip_q & irq_if.mie;

  // Wakeup ignores global enable
  assign irq_wakeup_o = |irq_pending;
  assign irq_req_o    = irq_wakeup_o && irq_if.m_irq_enable;

  assign irq_if.mip    = mip_q;
  assign irq_if.irq_id = core_irq_pkg::irq_priority_id(irq_pending);

  // Selected id always names a pending line
  a_id_pending : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) irq_wakeup_o |-> irq_pending[irq_if.irq_id]
  ) else $error("irq_id does not select a pending interrupt");

endmodule

/* hdl/sleep_unit.sv */
module sleep_unit (
  input  logic clk_i,
  input  logic rst_n_i,
  // Fetch enable, sampled every cycle
  input  logic fetch_enable_i,
  output logic fetch_enable_o,
  // WFI strobe and wakeup level
  input  logic wfi_i,
  input  logic irq_wakeup_i,
  // Sleep status
  output logic core_sleep_o
);

  logic fetch_enable_q;
  logic core_sleep_q;

  // Sticky until reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fetch_enable_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_enable_q <= 1'b1;
    end
  end

  ////////////////////
  // Sleep state

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      core_sleep_q <= 1'b0;
    end else if (irq_wakeup_i) begin
      // Wakeup exits sleep and blocks a coincident WFI
      core_sleep_q <= 1'b0;
    end else if (wfi_i && fetch_enable_q) begin
      core_sleep_q <= 1'b1;
    end
  end

  assign fetch_enable_o = fetch_enable_q;
  assign core_sleep_o   = core_sleep_q;

  // No sleep before fetch was ever enabled
  a_sleep_needs_fetch : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $rose(core_sleep_o) |-> $past(fetch_enable_o)
  ) else $error("core_sleep_o rose without fetch enable");

endmodule

/* hdl/core_irq_ctrl.sv */
module core_irq_ctrl #(
  parameter int unsigned IRQ_SYNC_STAGES = 2
) (
  // Clock and reset
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Interrupt lines
  input  logic [core_irq_pkg::XLEN-1:0]       irq_i,
  // CSR access
  input  logic                                csr_we_i,
  input  logic [core_irq_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [core_irq_pkg::XLEN-1:0]       csr_wdata_i,
  output logic [core_irq_pkg::XLEN-1:0]       csr_rdata_o,
  // Core events
  input  logic                                irq_ack_i,
  input  logic                                mret_i,
  input  logic                                wfi_i,
  input  logic                                fetch_enable_i,
  // Status
  output logic                                irq_req_o,
  output logic [core_irq_pkg::IRQ_ID_W-1:0]   irq_id_o,
  output logic                                core_sleep_o,
  output logic                                fetch_enable_o
);

  // CSR <-> interrupt controller
  irq_csr_if irq_if ();

  // Interrupt controller -> sleep unit
  logic irq_wakeup;

  irq_csr_regs csr_regs_i (
    .clk_i       ( clk_i       ),
    .rst_n_i     ( rst_n_i     ),
    .csr_we_i    ( csr_we_i    ),
    .csr_addr_i  ( csr_addr_i  ),
    .csr_wdata_i ( csr_wdata_i ),
    .csr_rdata_o ( csr_rdata_o ),
    .irq_ack_i   ( irq_ack_i   ),
    .mret_i      ( mret_i      ),
    .irq_if      ( irq_if.csr  )
  );

  int_controller #(
    .IRQ_SYNC_STAGES ( IRQ_SYNC_STAGES )
  ) int_controller_i (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .irq_i        ( irq_i       ),
    .irq_req_o    ( irq_req_o   ),
    .irq_wakeup_o ( irq_wakeup  ),
    .irq_if       ( irq_if.intc )
  );

  sleep_unit sleep_unit_i (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .fetch_enable_o ( fetch_enable_o ),
    .wfi_i          ( wfi_i          ),
    .irq_wakeup_i   ( irq_wakeup     ),
    .core_sleep_o   ( core_sleep_o   )
  );

  // Selected id straight from the controller
  assign irq_id_o = irq_if.irq_id;

endmodule

/* dv/core_irq_model.svh */
`ifndef CORE_IRQ_MODEL_SVH
`define CORE_IRQ_MODEL_SVH

////////////////////
// Random source

// Galois LFSR, one step per random bit
logic [31:0] lfsr_state = 32'h8bc3;

function automatic logic lfsr_next_bit();
  logic lsb;
  lsb = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (lsb)
    lfsr_state = lfsr_state ^ 32'hA300_0000;
  return lsb;
endfunction

// Collect n bits, LSB first
function automatic logic [31:0] rand_bits(input int n);
  logic [31:0] value;
  value = '0;
  for (int i = 0; i < n; i++) begin
    value[i] = lfsr_next_bit();
  end
  return value;
endfunction

////////////////////
// Reference model

// Sync line, mip and CSR state
logic [31:0] mdl_sync [SYNC_STAGES];
logic [31:0] mdl_mip;
logic [31:0] mdl_mie;
logic        mdl_mstatus_mie;
logic        mdl_mstatus_mpie;
logic        mdl_mcause_irq;
logic [4:0]  mdl_mcause_id;
// Sleep and sticky fetch enable
logic        mdl_sleep;
logic        mdl_fetch_en;

// Lowest priority first, later hits override
function automatic logic [4:0] pick_irq_id(input logic [31:0] pending);
  logic [4:0] id;
  id = 5'd0;
  if (pending[7])
    id = 5'd7;
  if (pending[3])
    id = 5'd3;
  if (pending[11])
    id = 5'd11;
  // Fast irqs beat everything, top index last
  for (int i = 16; i < 32; i++) begin
    if (pending[i])
      id = 5'(i);
  end
  return id;
endfunction

// Expected read data for an address
function automatic logic [31:0] read_csr(input logic [11:0] addr);
  logic [31:0] data;
  data = '0;
  case (addr)
    core_irq_pkg::CSR_MSTATUS: begin
      data[3] = mdl_mstatus_mie;
      data[7] = mdl_mstatus_mpie;
    end
    core_irq_pkg::CSR_MIE:    data = mdl_mie;
    core_irq_pkg::CSR_MIP:    data = mdl_mip;
    core_irq_pkg::CSR_MCAUSE: data = {mdl_mcause_irq, 26'd0, mdl_mcause_id};
    default: ;
  endcase
  return data;
endfunction

task automatic reset_model();
  for (int i = 0; i < SYNC_STAGES; i++) begin
    mdl_sync[i] = '0;
  end
  mdl_mip          = '0;
  mdl_mie          = '0;
  mdl_mstatus_mie  = 1'b0;
  mdl_mstatus_mpie = 1'b0;
  mdl_mcause_irq   = 1'b0;
  mdl_mcause_id    = '0;
  mdl_sleep        = 1'b0;
  mdl_fetch_en     = 1'b0;
endtask

// One rising edge, reads the inputs driven by the testbench
task automatic step_model();
  logic [31:0] pend;
  logic [4:0]  id;
  logic        old_mie;
  pend    = mdl_mip & mdl_mie;
  id      = pick_irq_id(pend);
  old_mie = mdl_mstatus_mie;
  // Wakeup wins over a coincident WFI
  if (|pend)
    mdl_sleep = 1'b0;
  else if (wfi_i && mdl_fetch_en)
    mdl_sleep = 1'b1;
  if (fetch_enable_i)
    mdl_fetch_en = 1'b1;
  if (irq_ack_i) begin
    mdl_mcause_irq = 1'b1;
    mdl_mcause_id  = id;
  end
  // Trap entry, then mret, then software write
  if (irq_ack_i) begin
    mdl_mstatus_mpie = old_mie;
    mdl_mstatus_mie  = 1'b0;
  end else if (mret_i) begin
    mdl_mstatus_mie  = mdl_mstatus_mpie;
    mdl_mstatus_mpie = 1'b1;
  end else if (csr_we_i && csr_addr_i == core_irq_pkg::CSR_MSTATUS) begin
    mdl_mstatus_mie  = csr_wdata_i[3];
    mdl_mstatus_mpie = csr_wdata_i[7];
  end
  if (csr_we_i && csr_addr_i == core_irq_pkg::CSR_MIE)
    mdl_mie = csr_wdata_i & core_irq_pkg::MIE_MASK;
  // mip takes the last stage before the line shifts
  mdl_mip = mdl_sync[SYNC_STAGES-1] & core_irq_pkg::MIE_MASK;
  for (int i = SYNC_STAGES - 1; i > 0; i--) begin
    mdl_sync[i] = mdl_sync[i-1];
  end
  mdl_sync[0] = irq_i;
endtask

`endif

/* dv/tb_core_irq_ctrl.sv */
module tb_core_irq_ctrl;

  localparam int SYNC_STAGES = 2;
  localparam int NUM_CYCLES  = 4000;
  localparam int CLK_PERIOD  = 4;

  // DUT signals
  logic        clk_i;
  logic        rst_n_i;
  logic [31:0] irq_i;
  logic        csr_we_i;
  logic [11:0] csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        irq_ack_i;
  logic        mret_i;
  logic        wfi_i;
  logic        fetch_enable_i;
  logic        irq_req_o;
  logic [4:0]  irq_id_o;
  logic        core_sleep_o;
  logic        fetch_enable_o;

  int unsigned error_count;
  int unsigned check_count;
  string       test_name;

  // Registers that must read zero out of reset
  logic [11:0] reset_addrs [4] = '{core_irq_pkg::CSR_MSTATUS, core_irq_pkg::CSR_MIE,
                                   core_irq_pkg::CSR_MCAUSE, core_irq_pkg::CSR_MIP};

  `include "core_irq_model.svh"

  core_irq_ctrl UUT (
    .clk_i          ( clk_i          ),
    .rst_n_i        ( rst_n_i        ),
    .irq_i          ( irq_i          ),
    .csr_we_i       ( csr_we_i       ),
    .csr_addr_i     ( csr_addr_i     ),
    .csr_wdata_i    ( csr_wdata_i    ),
    .csr_rdata_o    ( csr_rdata_o    ),
    .irq_ack_i      ( irq_ack_i      ),
    .mret_i         ( mret_i         ),
    .wfi_i          ( wfi_i          ),
    .fetch_enable_i ( fetch_enable_i ),
    .irq_req_o      ( irq_req_o      ),
    .irq_id_o       ( irq_id_o       ),
    .core_sleep_o   ( core_sleep_o   ),
    .fetch_enable_o ( fetch_enable_o )
  );

  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  // Model steps on the same edge as the DUT registers
  always @(posedge clk_i) begin
    if (!rst_n_i)
      reset_model();
    else
      step_model();
  end

  task automatic compare_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("ERROR %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  // Outputs settle well before the falling edge
  task automatic check_outputs();
    logic [31:0] pend;
    pend = mdl_mip & mdl_mie;
    compare_value("irq_req_o", 32'((|pend) && mdl_mstatus_mie), 32'(irq_req_o));
    compare_value("irq_id_o", 32'(pick_irq_id(pend)), 32'(irq_id_o));
    compare_value("core_sleep_o", 32'(mdl_sleep), 32'(core_sleep_o));
    compare_value("fetch_enable_o", 32'(mdl_fetch_en), 32'(fetch_enable_o));
    compare_value("csr_rdata_o", read_csr(csr_addr_i), csr_rdata_o);
  endtask

  task automatic drive_inputs();
    logic [2:0] sel;
    // Rare irq changes, half of them standard lines only
    if (rand_bits(5) == 0)
      irq_i = rand_bits(32) & (rand_bits(1) ? 32'h0000_0FFF : 32'hFFFF_FFFF);
    sel = rand_bits(3);
    case (sel)
      3'd0:       csr_addr_i = core_irq_pkg::CSR_MSTATUS;
      3'd1, 3'd5: csr_addr_i = core_irq_pkg::CSR_MIE;
      3'd2, 3'd6: csr_addr_i = core_irq_pkg::CSR_MIP;
      3'd3:       csr_addr_i = core_irq_pkg::CSR_MCAUSE;
      default:    csr_addr_i = rand_bits(12);
    endcase
    csr_we_i    = (rand_bits(3) == 0);
    csr_wdata_i = rand_bits(32);
    // Ack only on a live request, never with mret
    irq_ack_i      = irq_req_o && (rand_bits(2) == 0);
    mret_i         = !irq_ack_i && (rand_bits(4) == 0);
    wfi_i          = (rand_bits(3) == 0);
    fetch_enable_i = (rand_bits(7) == 0);
  endtask

  ////////////////////
  // Main sequence

  initial begin
    clk_i          = 1'b0;
    rst_n_i        = 1'b0;
    irq_i          = '0;
    csr_we_i       = 1'b0;
    csr_addr_i     = '0;
    csr_wdata_i    = '0;
    irq_ack_i      = 1'b0;
    mret_i         = 1'b0;
    wfi_i          = 1'b0;
    fetch_enable_i = 1'b0;
    error_count    = 0;
    check_count    = 0;
    test_name      = "after_reset";
    repeat (10) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    for (int i = 0; i < 4; i++) begin
      csr_addr_i = reset_addrs[i];
      @(negedge clk_i);
      check_outputs();
    end
    test_name = "random";
    for (int n = 0; n < NUM_CYCLES; n++) begin
      drive_inputs();
      @(negedge clk_i);
      check_outputs();
    end
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  // Watchdog, twice the expected run length
  initial begin
    #((NUM_CYCLES + 20) * CLK_PERIOD * 2);
    $display("Timeout: the tests did not reach their end in time");
    $display("Testbench failed");
    $finish;
  end

endmodule

/* tb.f */
+incdir+dv
hdl/core_irq_pkg.sv
hdl/irq_csr_if.sv
hdl/irq_csr_regs.sv
hdl/int_controller.sv
hdl/sleep_unit.sv
hdl/core_irq_ctrl.sv
dv/tb_core_irq_ctrl.sv

/* Bender.yml */
package:
  name: core_irq_ctrl

sources:
  - files:
      - hdl/core_irq_pkg.sv
      - hdl/irq_csr_if.sv
      - hdl/irq_csr_regs.sv
      - hdl/int_controller.sv
      - hdl/sleep_unit.sv
      - hdl/core_irq_ctrl.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/tb_core_irq_ctrl.sv
